//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary -j 0 --top-module tb_mips_execute -f all.f -Mdir obj_dir
	./obj_dir/Vtb_mips_execute

clean:
	rm -rf obj_dir

//--- address_unit.sv
`timescale 1ns/1ns

module address_unit (
  exec_operands_if.sink   ops,
  output mips_pkg::word_t effective_address_o,
  output logic            b_cond_met_o
);

  mips_pkg::word_t sext_imm;
  mips_pkg::word_t branch_target;
  mips_pkg::word_t jump_target;
  logic            rs_negative;
  logic            rs_zero;

  assign sext_imm    = {{16{ops.immediate[15]}}, ops.immediate};
  // Branch offsets are relative to the delay slot
  assign branch_target = ops.pc + 32'd4 + {sext_imm[29:0], 2'b00};
  // Jumps stay inside the current 256 MB region
  assign jump_target = {ops.pc[31:28], ops.target, 2'b00};
  assign rs_negative = ops.rs[31];
  assign rs_zero     = (ops.rs == '0);

  // Branch and jump condition
  always_comb begin
    b_cond_met_o = 1'b0;
    case (ops.opcode)
      mips_pkg::OP_BEQ:  b_cond_met_o = (ops.rs == ops.rt);
      mips_pkg::OP_BNE:  b_cond_met_o = (ops.rs != ops.rt);
      mips_pkg::OP_BLEZ: b_cond_met_o = rs_negative | rs_zero;
      mips_pkg::OP_BGTZ: b_cond_met_o = ~rs_negative & ~rs_zero;
      mips_pkg::OP_J,
      mips_pkg::OP_JAL:  b_cond_met_o = 1'b1;
      mips_pkg::OP_REGIMM: begin
        case (ops.regimm)
          mips_pkg::REGIMM_BLTZ,
          mips_pkg::REGIMM_BLTZAL: b_cond_met_o = rs_negative;
          mips_pkg::REGIMM_BGEZ,
          mips_pkg::REGIMM_BGEZAL: b_cond_met_o = ~rs_negative;
          default:                 b_cond_met_o = 1'b0;
        endcase
      end
      mips_pkg::OP_SPECIAL: begin
        b_cond_met_o = (ops.funct == mips_pkg::FUNC_JR) ||
                       (ops.funct == mips_pkg::FUNC_JALR);
      end
      default:           b_cond_met_o = 1'b0;
    endcase
  end

  // Memory address or control transfer target
  always_comb begin
    effective_address_o = '0;
    case (ops.opcode)
      mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
      mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW: begin
        effective_address_o = ops.rs + sext_imm;
      end
      mips_pkg::OP_BEQ, mips_pkg::OP_BNE,
      mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ: effective_address_o = branch_target;
      mips_pkg::OP_REGIMM: begin
        case (ops.regimm)
          mips_pkg::REGIMM_BLTZ, mips_pkg::REGIMM_BGEZ,
          mips_pkg::REGIMM_BLTZAL, mips_pkg::REGIMM_BGEZAL: begin
            effective_address_o = branch_target;
          end
          default: effective_address_o = '0;
        endcase
      end
      mips_pkg::OP_J, mips_pkg::OP_JAL: effective_address_o = jump_target;
      mips_pkg::OP_SPECIAL: begin
        if (ops.funct == mips_pkg::FUNC_JR || ops.funct == mips_pkg::FUNC_JALR) begin
          effective_address_o = ops.rs;
        end
      end
      default: effective_address_o = '0;
    endcase
  end

endmodule

//--- all.f
mips_pkg.sv
exec_operands_if.sv
alu.sv
address_unit.sv
hilo_unit.sv
mips_execute.sv
tb_mips_execute.sv

//--- alu.sv
`timescale 1ns/1ns

module alu (
  exec_operands_if.sink   ops,
  input  mips_pkg::word_t ram_readdata_i,
  output mips_pkg::word_t rd_o,
  output mips_pkg::word_t rt_o
);

  mips_pkg::word_t sext_imm;
  mips_pkg::word_t zext_imm;
  mips_pkg::word_t link_addr;
  logic [4:0]      shamt;
  logic [4:0]      shamt_var;

  assign sext_imm  = {{16{ops.immediate[15]}}, ops.immediate};
  assign zext_imm  = {16'b0, ops.immediate};
  // Return address skips the branch delay slot
  assign link_addr = ops.pc + 32'd8;
  // Fixed shifts use the sa field in instruction bits 10:6
  assign shamt     = ops.immediate[10:6];
  assign shamt_var = ops.rs[4:0];

  // Register-register results
  always_comb begin
    rd_o = '0;
    if (ops.opcode == mips_pkg::OP_SPECIAL) begin
      case (ops.funct)
        mips_pkg::FUNC_SLL:  rd_o = ops.rt << shamt;
        mips_pkg::FUNC_SRL:  rd_o = ops.rt >> shamt;
        mips_pkg::FUNC_SRA:  rd_o = $signed(ops.rt) >>> shamt;
        mips_pkg::FUNC_SLLV: rd_o = ops.rt << shamt_var;
        mips_pkg::FUNC_SRLV: rd_o = ops.rt >> shamt_var;
        mips_pkg::FUNC_SRAV: rd_o = $signed(ops.rt) >>> shamt_var;
        mips_pkg::FUNC_ADD,
        mips_pkg::FUNC_ADDU: rd_o = ops.rs + ops.rt;
        mips_pkg::FUNC_SUB,
        mips_pkg::FUNC_SUBU: rd_o = ops.rs - ops.rt;
        mips_pkg::FUNC_AND:  rd_o = ops.rs & ops.rt;
        mips_pkg::FUNC_OR:   rd_o = ops.rs | ops.rt;
        mips_pkg::FUNC_XOR:  rd_o = ops.rs ^ ops.rt;
        mips_pkg::FUNC_NOR:  rd_o = ~(ops.rs | ops.rt);
        mips_pkg::FUNC_SLT: begin
          rd_o = {31'b0, $signed(ops.rs) < $signed(ops.rt)};
        end
        mips_pkg::FUNC_SLTU: begin
          rd_o = {31'b0, ops.rs < ops.rt};
        end
        // JALR links through rd
        mips_pkg::FUNC_JALR: rd_o = link_addr;
        default:             rd_o = '0;
      endcase
    end
  end

  // Immediate, memory and link results on rt
  always_comb begin
    rt_o = '0;
    case (ops.opcode)
      mips_pkg::OP_ADDI,
      mips_pkg::OP_ADDIU: rt_o = ops.rs + sext_imm;
      mips_pkg::OP_SLTI: begin
        rt_o = {31'b0, $signed(ops.rs) < $signed(sext_imm)};
      end
      // Sign-extended immediate compared as unsigned
      mips_pkg::OP_SLTIU: begin
        rt_o = {31'b0, ops.rs < sext_imm};
      end
      mips_pkg::OP_ANDI:  rt_o = ops.rs & zext_imm;
      mips_pkg::OP_ORI:   rt_o = ops.rs | zext_imm;
      mips_pkg::OP_XORI:  rt_o = ops.rs ^ zext_imm;
      mips_pkg::OP_LUI:   rt_o = {ops.immediate, 16'b0};
      // Memory data is aligned from bit 31 downward
      mips_pkg::OP_LW:    rt_o = ram_readdata_i;
      mips_pkg::OP_LH: begin
        rt_o = {{16{ram_readdata_i[31]}}, ram_readdata_i[31:16]};
      end
      mips_pkg::OP_LB: begin
        rt_o = {{24{ram_readdata_i[31]}}, ram_readdata_i[31:24]};
      end
      mips_pkg::OP_SW:    rt_o = ops.rt;
      mips_pkg::OP_SH:    rt_o = {ops.rt[15:0], 16'b0};
      mips_pkg::OP_SB:    rt_o = {ops.rt[7:0], 24'b0};
      mips_pkg::OP_JAL:   rt_o = link_addr;
      mips_pkg::OP_REGIMM: begin
        // Linking branches write the return address whether taken or not
        if (ops.regimm == mips_pkg::REGIMM_BLTZAL ||
            ops.regimm == mips_pkg::REGIMM_BGEZAL) begin
          rt_o = link_addr;
        end
      end
      default:            rt_o = '0;
    endcase
  end

endmodule

//--- exec_operands_if.sv
`timescale 1ns/1ns

interface exec_operands_if;

  // Decoded instruction fields
  mips_pkg::opcode_t opcode;
  mips_pkg::func_t   funct;
  mips_pkg::regimm_t regimm;
  logic [15:0]       immediate;
  logic [25:0]       target;

  // Register operands and the PC of the instruction
  mips_pkg::word_t   rs;
  mips_pkg::word_t   rt;
  mips_pkg::word_t   pc;

  modport source (
    output opcode, funct, regimm, immediate, target, rs, rt, pc
  );

  modport sink (
    input opcode, funct, regimm, immediate, target, rs, rt, pc
  );

endinterface

//--- hilo_unit.sv
`timescale 1ns/1ns

module hilo_unit (
  input  logic            clk,
  input  logic            reset_i,
  exec_operands_if.sink   ops,
  output mips_pkg::word_t mfhi_o,
  output mips_pkg::word_t mflo_o
);

  mips_pkg::hilo_t hilo_q;
  mips_pkg::hilo_t prod_signed;
  mips_pkg::hilo_t prod_unsigned;
  mips_pkg::hilo_t div_signed;
  mips_pkg::hilo_t div_unsigned;
  logic            div_by_zero;

  // Operands widened to 64 bits so the low 64 bits of the product are exact
  assign prod_signed   = {{32{ops.rs[31]}}, ops.rs} * {{32{ops.rt[31]}}, ops.rt};
  assign prod_unsigned = {32'b0, ops.rs} * {32'b0, ops.rt};
  assign div_by_zero   = (ops.rt == '0);

  // Remainder goes to HI and quotient to LO
  // A zero divisor leaves both at zero
  always_comb begin
    div_signed   = '0;
    div_unsigned = '0;
    if (!div_by_zero) begin
      div_signed.hi   = $signed(ops.rs) % $signed(ops.rt);
      div_signed.lo   = $signed(ops.rs) / $signed(ops.rt);
      div_unsigned.hi = ops.rs % ops.rt;
      div_unsigned.lo = ops.rs / ops.rt;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      hilo_q <= '0;
    end else if (ops.opcode == mips_pkg::OP_SPECIAL) begin
      case (ops.funct)
        mips_pkg::FUNC_MULT:  hilo_q    <= prod_signed;
        mips_pkg::FUNC_MULTU: hilo_q    <= prod_unsigned;
        mips_pkg::FUNC_DIV:   hilo_q    <= div_signed;
        mips_pkg::FUNC_DIVU:  hilo_q    <= div_unsigned;
        mips_pkg::FUNC_MTHI:  hilo_q.hi <= ops.rs;
        mips_pkg::FUNC_MTLO:  hilo_q.lo <= ops.rs;
        default: ;
      endcase
    end
  end

  assign mfhi_o = hilo_q.hi;
  assign mflo_o = hilo_q.lo;

endmodule

//--- mips_execute.sv
`timescale 1ns/1ns

module mips_execute (
  input  logic              clk,
  input  logic              reset_i,
  input  mips_pkg::opcode_t opcode_i,
  input  mips_pkg::func_t   funct_i,
  input  mips_pkg::regimm_t regimm_i,
  input  mips_pkg::word_t   rs_i,
  input  mips_pkg::word_t   rt_i,
  input  logic [15:0]       immediate_i,
  input  logic [25:0]       target_i,
  input  mips_pkg::word_t   pc_i,
  input  mips_pkg::word_t   ram_readdata_i,
  output mips_pkg::word_t   rd_o,
  output mips_pkg::word_t   rt_o,
  output mips_pkg::word_t   effective_address_o,
  output logic              b_cond_met_o,
  output mips_pkg::word_t   mfhi_o,
  output mips_pkg::word_t   mflo_o
);

  // Decoded instruction shared by all three units
  exec_operands_if ops ();

  assign ops.opcode    = opcode_i;
  assign ops.funct     = funct_i;
  assign ops.regimm    = regimm_i;
  assign ops.rs        = rs_i;
  assign ops.rt        = rt_i;
  assign ops.immediate = immediate_i;
  assign ops.target    = target_i;
  assign ops.pc        = pc_i;

  alu alu_i (
    .ops            (ops.sink),
    .ram_readdata_i (ram_readdata_i),
    .rd_o           (rd_o),
    .rt_o           (rt_o)
  );

  address_unit address_unit_i (
    .ops                 (ops.sink),
    .effective_address_o (effective_address_o),
    .b_cond_met_o        (b_cond_met_o)
  );

  // Only HI/LO holds state across instructions
  hilo_unit hilo_unit_i (
    .clk     (clk),
    .reset_i (reset_i),
    .ops     (ops.sink),
    .mfhi_o  (mfhi_o),
    .mflo_o  (mflo_o)
  );

endmodule

//--- mips_pkg.sv
package mips_pkg;

  // One data or address word
  typedef logic [31:0] word_t;

  // HI holds the product high word or the remainder,
  // LO holds the product low word or the quotient
  typedef struct packed {
    word_t hi;
    word_t lo;
  } hilo_t;

  // Primary opcode from instruction bits 31:26
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_REGIMM  = 6'h01,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_BLEZ    = 6'h06,
    OP_BGTZ    = 6'h07,
    OP_ADDI    = 6'h08,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_SLTIU   = 6'h0b,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f,
    OP_LB      = 6'h20,
    OP_LH      = 6'h21,
    OP_LW      = 6'h23,
    OP_SB      = 6'h28,
    OP_SH      = 6'h29,
    OP_SW      = 6'h2b
  } opcode_t;

  // SPECIAL function field from instruction bits 5:0
  typedef enum logic [5:0] {
    FUNC_SLL   = 6'h00,
    FUNC_SRL   = 6'h02,
    FUNC_SRA   = 6'h03,
    FUNC_SLLV  = 6'h04,
    FUNC_SRLV  = 6'h06,
    FUNC_SRAV  = 6'h07,
    FUNC_JR    = 6'h08,
    FUNC_JALR  = 6'h09,
    FUNC_MTHI  = 6'h11,
    FUNC_MTLO  = 6'h13,
    FUNC_MULT  = 6'h18,
    FUNC_MULTU = 6'h19,
    FUNC_DIV   = 6'h1a,
    FUNC_DIVU  = 6'h1b,
    FUNC_ADD   = 6'h20,
    FUNC_ADDU  = 6'h21,
    FUNC_SUB   = 6'h22,
    FUNC_SUBU  = 6'h23,
    FUNC_AND   = 6'h24,
    FUNC_OR    = 6'h25,
    FUNC_XOR   = 6'h26,
    FUNC_NOR   = 6'h27,
    FUNC_SLT   = 6'h2a,
    FUNC_SLTU  = 6'h2b
  } func_t;

  // REGIMM branches are selected by the rt field
  typedef enum logic [4:0] {
    REGIMM_BLTZ   = 5'h00,
    REGIMM_BGEZ   = 5'h01,
    REGIMM_BLTZAL = 5'h10,
    REGIMM_BGEZAL = 5'h11
  } regimm_t;

endpackage

//--- tb_mips_execute.sv
`timescale 1ns/1ns

module tb_mips_execute;

  localparam int NUM_DIRECTED = 12;
  localparam int NUM_RANDOM   = 400;
  // One trailing vector lets the last HI/LO write be compared
  localparam int NUM_VECTORS  = NUM_DIRECTED + NUM_RANDOM + 1;

  typedef struct packed {
    mips_pkg::word_t rd;
    mips_pkg::word_t rt;
    mips_pkg::word_t ea;
    logic            cond;
    mips_pkg::hilo_t hilo;
  } exec_result_t;

  logic              clk;
  logic              reset_i;
  mips_pkg::opcode_t opcode_i;
  mips_pkg::func_t   funct_i;
  mips_pkg::regimm_t regimm_i;
  mips_pkg::word_t   rs_i;
  mips_pkg::word_t   rt_i;
  logic [15:0]       immediate_i;
  logic [25:0]       target_i;
  mips_pkg::word_t   pc_i;
  mips_pkg::word_t   ram_readdata_i;
  mips_pkg::word_t   rd_o;
  mips_pkg::word_t   rt_o;
  mips_pkg::word_t   effective_address_o;
  logic              b_cond_met_o;
  mips_pkg::word_t   mfhi_o;
  mips_pkg::word_t   mflo_o;

  integer            seed = 83169;
  int                vectors_sent = 0;
  int                checks_done = 0;
  mips_pkg::hilo_t   hilo_model = '0;
  exec_result_t      expected;

  mips_execute dut_i (.*);

  always #10 clk = ~clk;

  task automatic check_word(input string name, input mips_pkg::word_t exp_val,
                            input mips_pkg::word_t act_val);
    if (act_val !== exp_val) begin
      $display("error at %0t ns: %s expected %h actual %h", $time, name, exp_val, act_val);
      $display("CHECKS FAILED");
      $fatal(1, "%s does not match the reference model", name);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("error at %0t ns: %s expected %b actual %b", $time, name, exp_val, act_val);
      $display("CHECKS FAILED");
      $fatal(1, "%s does not match the reference model", name);
    end
  endtask

  // Expected outputs and the HI/LO state after the next edge
  function automatic exec_result_t ref_exec(
    input mips_pkg::opcode_t op, input mips_pkg::func_t fn, input mips_pkg::regimm_t ri,
    input mips_pkg::word_t rs, input mips_pkg::word_t rt, input logic [15:0] imm,
    input logic [25:0] tgt, input mips_pkg::word_t pc, input mips_pkg::word_t mem,
    input mips_pkg::hilo_t hilo
  );
    exec_result_t    r;
    mips_pkg::word_t simm;
    mips_pkg::word_t sign_bit;
    logic [63:0]     wide;
    longint          sx;
    longint          sy;
    r        = '0;
    r.hilo   = hilo;
    simm     = {{16{imm[15]}}, imm};
    sign_bit = 32'h8000_0000;
    sx       = {{32{rs[31]}}, rs};
    sy       = {{32{rt[31]}}, rt};
    if (op == mips_pkg::OP_SPECIAL) begin
      case (fn)
        mips_pkg::FUNC_SLL:  r.rd = rt << imm[10:6];
        mips_pkg::FUNC_SRL:  r.rd = rt >> imm[10:6];
        mips_pkg::FUNC_SLLV: r.rd = rt << rs[4:0];
        mips_pkg::FUNC_SRLV: r.rd = rt >> rs[4:0];
        // Arithmetic shift as a logical shift of the sign-extended word
        mips_pkg::FUNC_SRA, mips_pkg::FUNC_SRAV: begin
          wide = {{32{rt[31]}}, rt} >> ((fn == mips_pkg::FUNC_SRA) ? imm[10:6] : rs[4:0]);
          r.rd = wide[31:0];
        end
        mips_pkg::FUNC_ADD, mips_pkg::FUNC_ADDU: r.rd = rs + rt;
        mips_pkg::FUNC_SUB, mips_pkg::FUNC_SUBU: r.rd = rs - rt;
        mips_pkg::FUNC_AND:  r.rd = rs & rt;
        mips_pkg::FUNC_OR:   r.rd = rs | rt;
        mips_pkg::FUNC_XOR:  r.rd = rs ^ rt;
        mips_pkg::FUNC_NOR:  r.rd = ~(rs | rt);
        // Flipped sign bits make the signed order an unsigned one
        mips_pkg::FUNC_SLT:  r.rd = {31'b0, (rs ^ sign_bit) < (rt ^ sign_bit)};
        mips_pkg::FUNC_SLTU: r.rd = {31'b0, rs < rt};
        mips_pkg::FUNC_JR, mips_pkg::FUNC_JALR: begin
          r.cond = 1'b1;
          r.ea   = rs;
          if (fn == mips_pkg::FUNC_JALR) r.rd = pc + 32'd8;
        end
        mips_pkg::FUNC_MTHI:  r.hilo.hi = rs;
        mips_pkg::FUNC_MTLO:  r.hilo.lo = rs;
        mips_pkg::FUNC_MULT:  r.hilo = sx * sy;
        mips_pkg::FUNC_MULTU: r.hilo = {32'b0, rs} * {32'b0, rt};
        mips_pkg::FUNC_DIV, mips_pkg::FUNC_DIVU: begin
          // Zero divisor clears both halves
          r.hilo = '0;
          if (rt != '0 && fn == mips_pkg::FUNC_DIV) begin
            wide      = sx / sy;
            r.hilo.lo = wide[31:0];
            wide      = sx % sy;
            r.hilo.hi = wide[31:0];
          end else if (rt != '0) begin
            r.hilo.lo = rs / rt;
            r.hilo.hi = rs % rt;
          end
        end
        default: ;
      endcase
    end else begin
      case (op)
        mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: r.rt = rs + simm;
        mips_pkg::OP_SLTI:  r.rt = {31'b0, (rs ^ sign_bit) < (simm ^ sign_bit)};
        mips_pkg::OP_SLTIU: r.rt = {31'b0, rs < simm};
        mips_pkg::OP_ANDI:  r.rt = rs & {16'b0, imm};
        mips_pkg::OP_ORI:   r.rt = rs | {16'b0, imm};
        mips_pkg::OP_XORI:  r.rt = rs ^ {16'b0, imm};
        mips_pkg::OP_LUI:   r.rt = {imm, 16'b0};
        mips_pkg::OP_LW:    r.rt = mem;
        mips_pkg::OP_LH:    r.rt = {{16{mem[31]}}, mem[31:16]};
        mips_pkg::OP_LB:    r.rt = {{24{mem[31]}}, mem[31:24]};
        mips_pkg::OP_SW:    r.rt = rt;
        mips_pkg::OP_SH:    r.rt = {rt[15:0], 16'b0};
        mips_pkg::OP_SB:    r.rt = {rt[7:0], 24'b0};
        mips_pkg::OP_J, mips_pkg::OP_JAL: begin
          r.cond = 1'b1;
          r.ea   = {pc[31:28], tgt, 2'b00};
        end
        mips_pkg::OP_BEQ:   r.cond = (rs == rt);
        mips_pkg::OP_BNE:   r.cond = (rs != rt);
        mips_pkg::OP_BLEZ:  r.cond = ($signed(rs) <= 0);
        mips_pkg::OP_BGTZ:  r.cond = ($signed(rs) > 0);
        mips_pkg::OP_REGIMM: begin
          if (ri == mips_pkg::REGIMM_BLTZ || ri == mips_pkg::REGIMM_BLTZAL) begin
            r.cond = ($signed(rs) < 0);
          end else begin
            r.cond = ($signed(rs) >= 0);
          end
        end
        default: ;
      endcase
      if (op inside {mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
                     mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW}) begin
        r.ea = rs + simm;
      end
      if (op inside {mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ,
                     mips_pkg::OP_BGTZ, mips_pkg::OP_REGIMM}) begin
        r.ea = pc + 32'd4 + (simm << 2);
      end
      // Link is written whether the branch is taken or not
      if (op == mips_pkg::OP_JAL || (op == mips_pkg::OP_REGIMM &&
          (ri == mips_pkg::REGIMM_BLTZAL || ri == mips_pkg::REGIMM_BGEZAL))) begin
        r.rt = pc + 32'd8;
      end
    end
    return r;
  endfunction

  // Random word with a bias toward the sign boundary
  function automatic mips_pkg::word_t pick_operand();
    mips_pkg::word_t rnd;
    rnd = $random(seed);
    case (rnd[2:0])
      3'd0:    return 32'h8000_0000;
      3'd1:    return 32'h7fff_ffff;
      3'd2:    return 32'h0000_0001;
      default: return $random(seed);
    endcase
  endfunction

  task automatic apply_vector(
    input mips_pkg::opcode_t op, input mips_pkg::func_t fn, input mips_pkg::regimm_t ri,
    input mips_pkg::word_t rs, input mips_pkg::word_t rt, input logic [15:0] imm,
    input logic [25:0] tgt, input mips_pkg::word_t pc, input mips_pkg::word_t mem
  );
    @(posedge clk);
    opcode_i       <= op;
    funct_i        <= fn;
    regimm_i       <= ri;
    rs_i           <= rs;
    rt_i           <= rt;
    immediate_i    <= imm;
    target_i       <= tgt;
    pc_i           <= pc;
    ram_readdata_i <= mem;
    vectors_sent = vectors_sent + 1;
  endtask

  task automatic apply_special(input mips_pkg::func_t fn, input mips_pkg::word_t rs,
                               input mips_pkg::word_t rt, input logic [15:0] imm);
    apply_vector(mips_pkg::OP_SPECIAL, fn, mips_pkg::REGIMM_BLTZ, rs, rt, imm, '0, '0, '0);
  endtask

  task automatic apply_random();
    mips_pkg::opcode_t op;
    mips_pkg::func_t   fn;
    mips_pkg::regimm_t ri;
    mips_pkg::word_t   rs;
    mips_pkg::word_t   rt;
    mips_pkg::word_t   rnd;
    mips_pkg::word_t   fields;
    mips_pkg::word_t   pc;
    op  = op.first();
    fn  = fn.first();
    ri  = ri.first();
    rnd = $random(seed);
    // Half of the vectors stay SPECIAL so every function comes up often
    if (rnd[0]) begin
      repeat (int'(rnd[15:8]) % op.num()) op = op.next();
    end
    repeat (int'(rnd[23:16]) % fn.num()) fn = fn.next();
    repeat (int'(rnd[31:24]) % ri.num()) ri = ri.next();
    rs = pick_operand();
    rt = pick_operand();
    // Equal operands, zero divisor or zero rs now and then
    case (rnd[4:2])
      3'd0:    rt = rs;
      3'd1:    rt = '0;
      3'd2:    rs = '0;
      default: ;
    endcase
    fields = $random(seed);
    pc     = $random(seed);
    apply_vector(op, fn, ri, rs, rt, fields[15:0], fields[31:6], {pc[31:2], 2'b00},
                 $random(seed));
  endtask

  // Compare half a period after each edge
  always @(negedge clk) begin
    if (!reset_i) begin
      expected = ref_exec(opcode_i, funct_i, regimm_i, rs_i, rt_i, immediate_i, target_i,
                          pc_i, ram_readdata_i, hilo_model);
      check_word("rd_o", expected.rd, rd_o);
      check_word("rt_o", expected.rt, rt_o);
      check_word("effective_address_o", expected.ea, effective_address_o);
      check_bit("b_cond_met_o", expected.cond, b_cond_met_o);
      check_word("mfhi_o", hilo_model.hi, mfhi_o);
      check_word("mflo_o", hilo_model.lo, mflo_o);
      // HI/LO takes this value at the coming edge
      hilo_model  = expected.hilo;
      checks_done = checks_done + 1;
    end
  end

  initial begin
    clk            = 1'b0;
    reset_i        = 1'b1;
    opcode_i       = mips_pkg::OP_SPECIAL;
    funct_i        = mips_pkg::FUNC_SLL;
    regimm_i       = mips_pkg::REGIMM_BLTZ;
    rs_i           = '0;
    rt_i           = '0;
    immediate_i    = '0;
    target_i       = '0;
    pc_i           = '0;
    ram_readdata_i = '0;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;
    apply_special(mips_pkg::FUNC_MULT, 32'hffff_fff9, 32'd3, 16'h0);
    apply_special(mips_pkg::FUNC_DIV, 32'd100, 32'd0, 16'h0);
    apply_special(mips_pkg::FUNC_MULTU, 32'hffff_ffff, 32'hffff_ffff, 16'h0);
    apply_special(mips_pkg::FUNC_MTHI, 32'h1234_5678, 32'd0, 16'h0);
    apply_special(mips_pkg::FUNC_MTLO, 32'h9abc_def0, 32'd0, 16'h0);
    apply_special(mips_pkg::FUNC_DIVU, 32'd7, 32'd0, 16'h0);
    apply_special(mips_pkg::FUNC_DIV, 32'hffff_ff9c, 32'd7, 16'h0);
    apply_special(mips_pkg::FUNC_SLT, 32'h8000_0000, 32'd1, 16'h0);
    apply_special(mips_pkg::FUNC_SLTU, 32'h8000_0000, 32'd1, 16'h0);
    apply_special(mips_pkg::FUNC_SRA, 32'd0, 32'h8000_0010, 16'h0100);
    apply_special(mips_pkg::FUNC_SRAV, 32'd7, 32'hf000_0000, 16'h0);
    apply_special(mips_pkg::FUNC_NOR, 32'h0f0f_00ff, 32'h00f0_f000, 16'h0);
    repeat (NUM_RANDOM) apply_random();
    apply_special(mips_pkg::FUNC_SLL, '0, '0, '0);
    wait (checks_done == vectors_sent + 1);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    #(NUM_VECTORS * 20 * 2 + 1000);
    $display("CHECKS FAILED");
    $fatal(1, "timeout: the run did not finish after %0d vectors", vectors_sent);
  end

endmodule
